// File: src/patch_embed_config.svh
`ifndef PATCH_EMBED_CONFIG_SVH
`define PATCH_EMBED_CONFIG_SVH

// image geometry.
`define PE_IMG_W 4
`define PE_IMG_H 4
`define PE_IN_C 2
`define PE_PATCH 2

// projection shape, OUT_C split into groups of UNROLL lanes.
`define PE_OUT_C 4
`define PE_UNROLL 2

// mxint widths.
`define PE_MANT_W 8
`define PE_EXP_W 4
`define PE_OUT_MANT_W 16

`endif

// File: src/patch_embed_pkg.sv
`include "patch_embed_config.svh"

package patch_embed_pkg;

  localparam int POSITIONS = `PE_PATCH * `PE_PATCH;
  localparam int GROUPS = `PE_OUT_C / `PE_UNROLL;
  localparam int PATCHES = (`PE_IMG_W / `PE_PATCH) * (`PE_IMG_H / `PE_PATCH);
  localparam int ACC_W = 2 * `PE_MANT_W + $clog2(POSITIONS * `PE_IN_C) + 1;

  typedef logic signed [`PE_MANT_W-1:0] mant_t;
  typedef logic [`PE_EXP_W-1:0] exp_t;
  typedef logic signed [`PE_OUT_MANT_W-1:0] out_mant_t;
  typedef logic [`PE_EXP_W:0] out_exp_t;  // sum of two exponents.
  typedef logic signed [ACC_W-1:0] acc_t;

  typedef struct packed {
    mant_t [`PE_IN_C-1:0] mant;
    exp_t exp;
  } pixel_beat_t;

  // positions in raster order inside the patch.
  typedef struct packed {
    mant_t [POSITIONS-1:0][`PE_IN_C-1:0] mant;
    exp_t exp;
  } patch_t;

  typedef struct packed {
    mant_t [`PE_UNROLL-1:0][`PE_IN_C-1:0] mant;
    exp_t exp;
  } weight_beat_t;

  typedef struct packed {
    out_mant_t [`PE_UNROLL-1:0] mant;
    out_exp_t exp;
  } out_beat_t;

endpackage

// File: src/patch_gatherer.sv
`timescale 1ns/1ps
`include "patch_embed_config.svh"

module patch_gatherer
  import patch_embed_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  pixel_beat_t pixel_in,
  input  logic        pixel_in_valid,
  output logic        pixel_in_ready,
  output patch_t      patch,
  output logic        patch_valid,
  input  logic        patch_ready
);

  localparam int COL_W = $clog2(`PE_IMG_W);
  localparam int ROW_W = $clog2(`PE_PATCH);

  pixel_beat_t      line_buf [`PE_PATCH][`PE_IMG_W];  // one band of patch rows.
  pixel_beat_t      win [POSITIONS];
  logic [COL_W-1:0] col;
  logic [COL_W-1:0] base;
  logic [ROW_W-1:0] row;  // row inside the band.
  logic             armed;
  logic             pixel_fire;
  logic             patch_done;
  exp_t             e_max;
  patch_t           aligned;

  assign pixel_in_ready = armed && (!patch_valid || patch_ready);
  assign pixel_fire = pixel_in_valid && pixel_in_ready;
  assign base = col - COL_W'(`PE_PATCH - 1);
  assign patch_done = pixel_fire && (row == ROW_W'(`PE_PATCH - 1)) &&
                      ((col % `PE_PATCH) == `PE_PATCH - 1);

  // ************************************************************************
  // window and exponent alignment
  // ************************************************************************

  always_comb begin
    for (int r = 0; r < `PE_PATCH; r++) begin
      for (int c = 0; c < `PE_PATCH; c++) begin
        win[r*`PE_PATCH + c] = line_buf[r][base + COL_W'(c)];
      end
    end
    win[POSITIONS-1] = pixel_in;  // bottom-right pixel not stored yet.
  end

  always_comb begin
    e_max = win[0].exp;
    for (int p = 1; p < POSITIONS; p++) begin
      if (win[p].exp > e_max) e_max = win[p].exp;
    end
    aligned.exp = e_max;
    for (int p = 0; p < POSITIONS; p++) begin
      for (int c = 0; c < `PE_IN_C; c++) begin
        aligned.mant[p][c] = $signed(win[p].mant[c]) >>> (e_max - win[p].exp);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pixel_fire) line_buf[row][col] <= pixel_in;
    if (patch_done) patch <= aligned;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      armed <= 1'b0;
      col <= '0;
      row <= '0;
      patch_valid <= 1'b0;
    end else begin
      armed <= 1'b1;
      if (pixel_fire) begin
        if (col == COL_W'(`PE_IMG_W - 1)) begin
          col <= '0;
          row <= (row == ROW_W'(`PE_PATCH - 1)) ? '0 : row + 1'b1;
        end else begin
          col <= col + 1'b1;
        end
      end
      if (patch_done) patch_valid <= 1'b1;
      else if (patch_ready) patch_valid <= 1'b0;
    end
  end

  // a finished patch holds until the projector takes it.
  a_hold_patch: assert property (@(posedge clk) disable iff (rst)
    patch_valid && !patch_ready |=> patch_valid && $stable(patch));

endmodule

// File: src/weight_replay_buffer.sv
`timescale 1ns/1ps

module weight_replay_buffer
  import patch_embed_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  weight_beat_t weight_in,
  input  logic         weight_in_valid,
  output logic         weight_in_ready,
  output weight_beat_t weight,
  output logic         weight_valid,
  input  logic         weight_ready
);

  localparam int DEPTH = GROUPS * POSITIONS;
  localparam int PTR_W = $clog2(DEPTH);

  weight_beat_t     mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             loaded;
  logic             load_fire;
  logic             last_write;

  assign weight_in_ready = !loaded;
  assign load_fire = weight_in_valid && weight_in_ready;
  assign last_write = wr_ptr == PTR_W'(DEPTH - 1);

  assign weight = mem[rd_ptr];
  assign weight_valid = loaded;

  always_ff @(posedge clk) begin
    if (load_fire) mem[wr_ptr] <= weight_in;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      loaded <= 1'b0;
    end else begin
      if (load_fire) begin
        wr_ptr <= last_write ? '0 : wr_ptr + 1'b1;
        if (last_write) loaded <= 1'b1;
      end
      if (weight_valid && weight_ready) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;  // circular.
      end
    end
  end

  // a stalled replay beat stays put.
  a_hold_weight: assert property (@(posedge clk) disable iff (rst)
    weight_valid && !weight_ready |=> weight_valid && $stable(weight));

endmodule

// File: src/patch_projector.sv
`timescale 1ns/1ps
`include "patch_embed_config.svh"

module patch_projector
  import patch_embed_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  patch_t       patch,
  input  logic         patch_valid,
  output logic         patch_ready,
  input  weight_beat_t weight,
  input  logic         weight_valid,
  output logic         weight_ready,
  output out_beat_t    proj,
  output logic         proj_valid,
  input  logic         proj_ready
);

  localparam int POS_W = $clog2(POSITIONS);
  localparam int GRP_W = $clog2(GROUPS);

  patch_t           patch_reg;
  logic             patch_full;
  logic [POS_W-1:0] pos;
  logic [GRP_W-1:0] grp;
  acc_t             acc [`PE_UNROLL];
  acc_t             step_sum [`PE_UNROLL];
  exp_t             w_exp;  // exponent of the group's first weight beat.
  exp_t             first_exp;
  logic             step;
  logic             last_pos;
  logic             last_grp;

  function automatic out_mant_t saturate(input acc_t v);
    out_mant_t hi;
    out_mant_t lo;
    hi = {1'b0, {(`PE_OUT_MANT_W-1){1'b1}}};
    lo = {1'b1, {(`PE_OUT_MANT_W-1){1'b0}}};
    if (v > acc_t'(hi)) return hi;
    if (v < acc_t'(lo)) return lo;
    return out_mant_t'(v);
  endfunction

  assign patch_ready = !patch_full;
  assign weight_ready = patch_full && !(proj_valid && !proj_ready);
  assign step = weight_valid && weight_ready;
  assign last_pos = pos == POS_W'(POSITIONS - 1);
  assign last_grp = grp == GRP_W'(GROUPS - 1);
  assign first_exp = (pos == '0) ? weight.exp : w_exp;

  // ************************************************************************
  // one MAC step per weight beat
  // ************************************************************************

  always_comb begin
    for (int l = 0; l < `PE_UNROLL; l++) begin
      step_sum[l] = (pos == '0) ? '0 : acc[l];
      for (int c = 0; c < `PE_IN_C; c++) begin
        step_sum[l] = step_sum[l] +
                      acc_t'($signed(patch_reg.mant[pos][c]) * $signed(weight.mant[l][c]));
      end
    end
  end

  always_ff @(posedge clk) begin
    if (patch_valid && patch_ready) patch_reg <= patch;
    if (step) begin
      for (int l = 0; l < `PE_UNROLL; l++) begin
        acc[l] <= step_sum[l];
      end
      w_exp <= first_exp;
    end
    if (step && last_pos) begin
      for (int l = 0; l < `PE_UNROLL; l++) begin
        proj.mant[l] <= saturate(step_sum[l]);
      end
      proj.exp <= out_exp_t'(first_exp) + out_exp_t'(patch_reg.exp);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      patch_full <= 1'b0;
      pos <= '0;
      grp <= '0;
      proj_valid <= 1'b0;
    end else begin
      if (patch_valid && patch_ready) patch_full <= 1'b1;
      if (step) begin
        pos <= last_pos ? '0 : pos + 1'b1;
        if (last_pos) begin
          grp <= last_grp ? '0 : grp + 1'b1;
          if (last_grp) patch_full <= 1'b0;  // release after final group.
        end
      end
      if (step && last_pos) proj_valid <= 1'b1;
      else if (proj_ready) proj_valid <= 1'b0;
    end
  end

endmodule

// File: src/token_sequencer.sv
`timescale 1ns/1ps

module token_sequencer
  import patch_embed_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  out_beat_t cls_in,
  input  logic      cls_in_valid,
  output logic      cls_in_ready,
  input  out_beat_t distill_in,
  input  logic      distill_in_valid,
  output logic      distill_in_ready,
  input  out_beat_t proj,
  input  logic      proj_valid,
  output logic      proj_ready,
  output out_beat_t data_out,
  output logic      data_out_valid,
  input  logic      data_out_ready
);

  localparam int FRAME_BEATS = (2 + PATCHES) * GROUPS;
  localparam int CNT_W = $clog2(FRAME_BEATS);

  typedef enum logic [1:0] {cls_phase, distill_phase, patch_phase} phase_t;

  logic [CNT_W-1:0] count;
  phase_t           phase;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (data_out_valid && data_out_ready) begin
      count <= (count == CNT_W'(FRAME_BEATS - 1)) ? '0 : count + 1'b1;  // frame end.
    end
  end

  always_comb begin
    if (count < CNT_W'(GROUPS)) phase = cls_phase;
    else if (count < CNT_W'(2 * GROUPS)) phase = distill_phase;
    else phase = patch_phase;
  end

  always_comb begin
    data_out = proj;
    data_out_valid = proj_valid;
    cls_in_ready = 1'b0;
    distill_in_ready = 1'b0;
    proj_ready = 1'b0;
    case (phase)
      cls_phase: begin
        data_out = cls_in;
        data_out_valid = cls_in_valid;
        cls_in_ready = data_out_ready;
      end
      distill_phase: begin
        data_out = distill_in;
        data_out_valid = distill_in_valid;
        distill_in_ready = data_out_ready;
      end
      default: proj_ready = data_out_ready;
    endcase
  end

  // every selected source must hold its beat through a stall.
  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    data_out_valid && !data_out_ready |=> data_out_valid && $stable(data_out));

endmodule

// File: src/mx_patch_embed.sv
`timescale 1ns/1ps

module mx_patch_embed
  import patch_embed_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  pixel_beat_t  pixel_in,
  input  logic         pixel_in_valid,
  output logic         pixel_in_ready,
  input  weight_beat_t weight_in,
  input  logic         weight_in_valid,
  output logic         weight_in_ready,
  input  out_beat_t    cls_in,
  input  logic         cls_in_valid,
  output logic         cls_in_ready,
  input  out_beat_t    distill_in,
  input  logic         distill_in_valid,
  output logic         distill_in_ready,
  output out_beat_t    data_out,
  output logic         data_out_valid,
  input  logic         data_out_ready
);

  patch_t       patch;
  logic         patch_valid;
  logic         patch_ready;
  weight_beat_t weight;
  logic         weight_valid;
  logic         weight_ready;
  out_beat_t    proj;
  logic         proj_valid;
  logic         proj_ready;

  patch_gatherer u_gatherer (
    .clk, .rst,
    .pixel_in, .pixel_in_valid, .pixel_in_ready,
    .patch, .patch_valid, .patch_ready
  );

  weight_replay_buffer u_weights (
    .clk, .rst,
    .weight_in, .weight_in_valid, .weight_in_ready,
    .weight, .weight_valid, .weight_ready
  );

  patch_projector u_projector (
    .clk, .rst,
    .patch, .patch_valid, .patch_ready,
    .weight, .weight_valid, .weight_ready,
    .proj, .proj_valid, .proj_ready
  );

  token_sequencer u_sequencer (
    .clk, .rst,
    .cls_in, .cls_in_valid, .cls_in_ready,
    .distill_in, .distill_in_valid, .distill_in_ready,
    .proj, .proj_valid, .proj_ready,
    .data_out, .data_out_valid, .data_out_ready
  );

endmodule

// File: bench/mx_patch_embed_tb.sv
`timescale 1ns/1ps
`include "patch_embed_config.svh"

module mx_patch_embed_tb
  import patch_embed_pkg::*;
();

  localparam int N_FRAMES = 6;
  localparam int FRAME_BEATS = (2 + PATCHES) * GROUPS;
  localparam int PIXELS = `PE_IMG_W * `PE_IMG_H;
  localparam int HEADERS = N_FRAMES * GROUPS;
  localparam int LIMIT = 1000;  // idle cycles per wait.
  localparam int SAT_MAX = (1 << (`PE_OUT_MANT_W - 1)) - 1;
  localparam int SAT_MIN = -(1 << (`PE_OUT_MANT_W - 1));
  localparam int RANDOM_KIND = 0;
  localparam int EQUAL_EXP = 1;
  localparam int MIXED_EXP = 2;
  localparam int EXTREME = 3;

  typedef struct packed {
    int kind;
    int stall_pct;
  } frame_row_t;

  localparam frame_row_t FRAME_TAB [N_FRAMES] = '{
    '{EQUAL_EXP, 0}, '{MIXED_EXP, 0}, '{EXTREME, 0},
    '{RANDOM_KIND, 30}, '{MIXED_EXP, 50}, '{RANDOM_KIND, 70}
  };

  logic         clk;
  logic         rst;
  pixel_beat_t  pixel_in;
  logic         pixel_in_valid;
  logic         pixel_in_ready;
  weight_beat_t weight_in;
  logic         weight_in_valid;
  logic         weight_in_ready;
  out_beat_t    cls_in;
  logic         cls_in_valid;
  logic         cls_in_ready;
  out_beat_t    distill_in;
  logic         distill_in_valid;
  logic         distill_in_ready;
  out_beat_t    data_out;
  logic         data_out_valid;
  logic         data_out_ready;

  weight_beat_t w_tab [GROUPS * POSITIONS];
  pixel_beat_t  pix [N_FRAMES][PIXELS];
  out_beat_t    exp_q [$];
  int           errors;
  int           timeouts;

  mx_patch_embed dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_beat(input out_beat_t got, input out_beat_t want, input string name);
    if (got !== want) begin
      errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, want);
    end
  endtask

  task automatic check_flag(input logic got, input logic want, input string name);
    if (got !== want) begin
      errors++;
      $display("FAIL %0t %s got %b expected %b", $time, name, got, want);
    end
  endtask

  // data_out_ready goes back only to the source of beat k of a frame.
  task automatic compare_readies(input int k);
    check_flag(cls_in_ready, data_out_ready && k < GROUPS, "cls_in_ready");
    check_flag(distill_in_ready, data_out_ready && k >= GROUPS && k < 2 * GROUPS,
               "distill_in_ready");
  endtask

  task automatic count_transfer(input logic fire, inout int n, inout int idle,
                                input string what);
    if (fire) begin
      n++;
      idle = 0;
    end else begin
      idle++;
    end
    if (idle > LIMIT) begin
      timeouts++;
      $display("timed out waiting %0d cycles for a %s transfer", LIMIT, what);
    end
  endtask

  function automatic int pixel_index(input int pt, input int p);
    int y;
    int x;
    y = (pt / (`PE_IMG_W / `PE_PATCH)) * `PE_PATCH + p / `PE_PATCH;
    x = (pt % (`PE_IMG_W / `PE_PATCH)) * `PE_PATCH + p % `PE_PATCH;
    return y * `PE_IMG_W + x;
  endfunction

  // n counts header beats over the whole run.
  function automatic out_beat_t header_beat(input int which, input int n);
    out_beat_t b;
    for (int l = 0; l < `PE_UNROLL; l++) b.mant[l] = out_mant_t'(which * 'h4000 - n * 37 + l);
    b.exp = out_exp_t'(n + which);
    return b;
  endfunction

  // **************************************************************************
  // stimulus and reference model
  // **************************************************************************

  task automatic make_stimulus();
    int e;
    int i;
    for (int w = 0; w < GROUPS * POSITIONS; w++) begin
      for (int l = 0; l < `PE_UNROLL; l++) begin
        for (int c = 0; c < `PE_IN_C; c++) begin
          w_tab[w].mant[l][c] = mant_t'($urandom);
          if (w < POSITIONS) w_tab[w].mant[l][c] = (l == 0) ? 8'sh7f : 8'sh80;  // both limits.
        end
      end
      w_tab[w].exp = exp_t'($urandom);
    end
    for (int f = 0; f < N_FRAMES; f++) begin
      e = $urandom % 16;
      for (int pt = 0; pt < PATCHES; pt++) begin
        for (int p = 0; p < POSITIONS; p++) begin
          i = pixel_index(pt, p);
          for (int c = 0; c < `PE_IN_C; c++) begin
            pix[f][i].mant[c] = mant_t'($urandom);
            if (FRAME_TAB[f].kind == EXTREME) pix[f][i].mant[c] = (pt % 2) ? 8'sh80 : 8'sh7f;
          end
          case (FRAME_TAB[f].kind)
            RANDOM_KIND: pix[f][i].exp = exp_t'($urandom);
            MIXED_EXP: pix[f][i].exp = exp_t'((3 * p + pt) % 16);  // shifts past 8 bits.
            default: pix[f][i].exp = exp_t'(e);
          endcase
        end
      end
    end
  endtask

  task automatic model_frame(input int f);
    int e_max;
    int s;
    int i;
    int a [POSITIONS][`PE_IN_C];
    out_beat_t b;
    for (int k = 0; k < GROUPS; k++) exp_q.push_back(header_beat(0, f * GROUPS + k));
    for (int k = 0; k < GROUPS; k++) exp_q.push_back(header_beat(1, f * GROUPS + k));
    for (int pt = 0; pt < PATCHES; pt++) begin
      e_max = 0;
      for (int p = 0; p < POSITIONS; p++) begin
        if (int'(pix[f][pixel_index(pt, p)].exp) > e_max) e_max = pix[f][pixel_index(pt, p)].exp;
      end
      for (int p = 0; p < POSITIONS; p++) begin
        i = pixel_index(pt, p);
        for (int c = 0; c < `PE_IN_C; c++) begin
          a[p][c] = int'($signed(pix[f][i].mant[c])) >>> (e_max - int'(pix[f][i].exp));
        end
      end
      for (int g = 0; g < GROUPS; g++) begin
        for (int l = 0; l < `PE_UNROLL; l++) begin
          s = 0;
          for (int p = 0; p < POSITIONS; p++) begin
            for (int c = 0; c < `PE_IN_C; c++) begin
              s += a[p][c] * int'($signed(w_tab[g * POSITIONS + p].mant[l][c]));
            end
          end
          if (s > SAT_MAX) s = SAT_MAX;
          else if (s < SAT_MIN) s = SAT_MIN;
          b.mant[l] = out_mant_t'(s);
        end
        b.exp = out_exp_t'(int'(w_tab[g * POSITIONS].exp) + e_max);
        exp_q.push_back(b);
      end
    end
  endtask

  // **************************************************************************
  // stream drivers and output monitor
  // **************************************************************************

  task automatic send_pixels();
    int n;
    int idle;
    n = 0;
    idle = 0;
    while (n < N_FRAMES * PIXELS && timeouts == 0) begin
      pixel_in = pix[n / PIXELS][n % PIXELS];
      pixel_in_valid = 1'b1;
      #1;
      count_transfer(pixel_in_ready, n, idle, "pixel_in");
      @(posedge clk);
      #2;
    end
    pixel_in_valid = 1'b0;
  endtask

  task automatic send_headers();
    int nc;
    int nd;
    int idle_c;
    int idle_d;
    nc = 0;
    nd = 0;
    idle_c = 0;
    idle_d = 0;
    while ((nc < HEADERS || nd < HEADERS) && timeouts == 0) begin
      cls_in = header_beat(0, nc);
      cls_in_valid = nc < HEADERS;
      distill_in = header_beat(1, nd);
      distill_in_valid = nd < HEADERS;
      #1;
      if (cls_in_valid) count_transfer(cls_in_ready, nc, idle_c, "cls_in");
      if (distill_in_valid) count_transfer(distill_in_ready, nd, idle_d, "distill_in");
      @(posedge clk);
      #2;
    end
    cls_in_valid = 1'b0;
    distill_in_valid = 1'b0;
  endtask

  task automatic watch_output();
    int n;
    int idle;
    n = 0;
    idle = 0;
    while (n < N_FRAMES * FRAME_BEATS && timeouts == 0) begin
      data_out_ready = ($urandom % 100) >= FRAME_TAB[n / FRAME_BEATS].stall_pct;
      #1;
      compare_readies(n % FRAME_BEATS);
      if (data_out_valid && data_out_ready) check_beat(data_out, exp_q.pop_front(), "data_out");
      count_transfer(data_out_valid && data_out_ready, n, idle, "data_out");
      @(posedge clk);
      #2;
    end
    data_out_ready = 1'b1;
    repeat (20) begin  // parked at a frame start, nothing left over.
      #1;
      compare_readies(0);
      check_flag(data_out_valid, 1'b0, "data_out_valid");
      @(posedge clk);
      #2;
    end
  endtask

  initial begin
    int n;
    int idle;
    void'($urandom(14));
    errors = 0;
    timeouts = 0;
    rst = 1'b1;
    pixel_in = '0;
    pixel_in_valid = 1'b0;
    weight_in = '0;
    weight_in_valid = 1'b0;
    cls_in = '0;
    cls_in_valid = 1'b0;
    distill_in = '0;
    distill_in_valid = 1'b0;
    data_out_ready = 1'b0;
    make_stimulus();
    for (int f = 0; f < N_FRAMES; f++) model_frame(f);
    repeat (2) begin
      @(posedge clk);
      #2;
      check_flag(pixel_in_ready, 1'b0, "pixel_in_ready");
      check_flag(data_out_valid, 1'b0, "data_out_valid");
    end
    rst = 1'b0;
    #1;
    check_flag(pixel_in_ready, 1'b0, "pixel_in_ready");
    @(posedge clk);
    #2;
    n = 0;
    idle = 0;
    while (n < GROUPS * POSITIONS && timeouts == 0) begin  // one weight load for all frames.
      weight_in = w_tab[n];
      weight_in_valid = 1'b1;
      #1;
      count_transfer(weight_in_ready, n, idle, "weight_in");
      @(posedge clk);
      #2;
    end
    weight_in_valid = 1'b0;
    #1;
    check_flag(weight_in_ready, 1'b0, "weight_in_ready");
    #1;
    fork
      send_pixels();
      send_headers();
      watch_output();
    join
    $display("closing report: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+src
src/patch_embed_pkg.sv
src/patch_gatherer.sv
src/weight_replay_buffer.sv
src/patch_projector.sv
src/token_sequencer.sv
src/mx_patch_embed.sv
bench/mx_patch_embed_tb.sv

// File: Makefile
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module mx_patch_embed_tb \
		-f list.f -o mx_patch_embed_sim
	./obj_dir/mx_patch_embed_sim | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
